//--- hdl/fpu_defines.svh
`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

`define FPU_W       32
`define FPU_BIAS    127
`define FPU_LATENCY 2

// funct5 opcodes of the floating-point instructions.
`define FPU_F5_FADD  5'b00000
`define FPU_F5_FSUB  5'b00001
`define FPU_F5_FMUL  5'b00010
`define FPU_F5_FSGNJ 5'b00100
`define FPU_F5_FCMP  5'b10100
`define FPU_F5_FTOI  5'b11000
`define FPU_F5_ITOF  5'b11010

// rm values that pick the sign-injection and compare variants.
`define FPU_RM_SGNJ  3'b000
`define FPU_RM_SGNJN 3'b001
`define FPU_RM_FEQ   3'b010
`define FPU_RM_FLT   3'b001

`define FPU_QNAN 32'h7fc00000

`endif

//--- hdl/fpu_pkg.sv
`include "fpu_defines.svh"

package fpu_pkg;

    // one entry per operation, with the rm variants already resolved.
    typedef enum logic [3:0] {
        OP_MUL,
        OP_FTOI,
        OP_ITOF,
        OP_SGNJ,
        OP_SGNJN,
        OP_SGNJX,
        OP_FEQ,
        OP_FLT,
        OP_FLE,
        OP_UNSUP
    } fpu_op_e;

    // fields of one operand; a subnormal is already flushed to zero here.
    typedef struct packed {
        logic        sign;
        logic [7:0]  exp;
        logic [22:0] mant;
        logic        is_zero;
        logic        is_inf;
        logic        is_nan;
    } fpu_class_t;

    typedef struct packed {
        logic                valid;
        fpu_op_e             op;
        logic [`FPU_W-1:0]   x;
        logic [`FPU_W-1:0]   y;
        fpu_class_t          xc;
        fpu_class_t          yc;
    } fpu_issue_t;

    typedef struct packed {
        logic              valid;
        logic [`FPU_W-1:0] data;
    } fpu_result_t;

endpackage

//--- hdl/fpu_decode.sv
`timescale 1ns/1ns
`default_nettype none
`include "fpu_defines.svh"

module fpu_decode (
    input  wire                 clk,
    input  wire                 rstn,
    input  wire                 en,
    input  wire [`FPU_W-1:0]    x,
    input  wire [`FPU_W-1:0]    y,
    input  wire [4:0]           funct5,
    input  wire [2:0]           rm,
    output fpu_pkg::fpu_issue_t issue
);

    fpu_pkg::fpu_op_e op;

    function automatic fpu_pkg::fpu_class_t classify(input logic [`FPU_W-1:0] w);
        fpu_pkg::fpu_class_t c;
        c.sign    = w[31];
        c.exp     = w[30:23];
        // subnormals keep their sign and lose the fraction.
        c.mant    = (w[30:23] == 8'd0) ? 23'd0 : w[22:0];
        c.is_zero = (w[30:23] == 8'd0);
        c.is_inf  = (w[30:23] == 8'hff) && (w[22:0] == 23'd0);
        c.is_nan  = (w[30:23] == 8'hff) && (w[22:0] != 23'd0);
        return c;
    endfunction

    always_comb begin
        case (funct5)
            `FPU_F5_FMUL: op = fpu_pkg::OP_MUL;
            `FPU_F5_FTOI: op = fpu_pkg::OP_FTOI;
            `FPU_F5_ITOF: op = fpu_pkg::OP_ITOF;
            `FPU_F5_FSGNJ: op = (rm == `FPU_RM_SGNJ)  ? fpu_pkg::OP_SGNJ  :
                                (rm == `FPU_RM_SGNJN) ? fpu_pkg::OP_SGNJN :
                                                        fpu_pkg::OP_SGNJX;
            `FPU_F5_FCMP: op = (rm == `FPU_RM_FEQ) ? fpu_pkg::OP_FEQ :
                               (rm == `FPU_RM_FLT) ? fpu_pkg::OP_FLT :
                                                     fpu_pkg::OP_FLE;
            // add and subtract have no datapath in this unit.
            default: op = fpu_pkg::OP_UNSUP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            issue.valid <= 1'b0;
        end else begin
            issue.valid <= en;
        end
        issue.op <= op;
        issue.x  <= x;
        issue.y  <= y;
        issue.xc <= classify(x);
        issue.yc <= classify(y);
    end

endmodule

`default_nettype wire

//--- hdl/fpu_mul.sv
`timescale 1ns/1ns
`default_nettype none
`include "fpu_defines.svh"

module fpu_mul (
    input  wire fpu_pkg::fpu_issue_t issue,
    output logic [`FPU_W-1:0]        res
);

    logic [47:0]       prod;
    logic signed [9:0] e_sum;
    logic [22:0]       mant;
    logic              sign;

    always_comb begin
        sign = issue.xc.sign ^ issue.yc.sign;
        prod = {1'b1, issue.xc.mant} * {1'b1, issue.yc.mant};
        // the product of two significands in [1,2) lies in [1,4), so one shift is enough.
        e_sum = 10'(issue.xc.exp) + 10'(issue.yc.exp) - 10'(`FPU_BIAS) + 10'(prod[47]);
        mant  = prod[47] ? prod[46:24] : prod[45:23];

        if (issue.xc.is_nan || issue.yc.is_nan ||
            (issue.xc.is_zero && issue.yc.is_inf) ||
            (issue.xc.is_inf && issue.yc.is_zero)) begin
            res = `FPU_QNAN;
        end else if (issue.xc.is_inf || issue.yc.is_inf) begin
            res = {sign, 8'hff, 23'd0};
        end else if (issue.xc.is_zero || issue.yc.is_zero) begin
            res = {sign, 31'd0};
        end else if (e_sum > 10'sd254) begin
            // round toward zero never overflows to infinity.
            res = {sign, 31'h7f7fffff};
        end else if (e_sum < 10'sd1) begin
            res = {sign, 31'd0};
        end else begin
            res = {sign, e_sum[7:0], mant};
        end
    end

endmodule

`default_nettype wire

//--- hdl/fpu_convert.sv
`timescale 1ns/1ns
`default_nettype none
`include "fpu_defines.svh"

module fpu_convert (
    input  wire fpu_pkg::fpu_issue_t issue,
    output logic [`FPU_W-1:0]        res
);

    logic [7:0]        shamt;
    logic [54:0]       wide;
    logic [30:0]       ftoi_mag;
    logic [`FPU_W-1:0] ftoi_res;
    logic [`FPU_W-1:0] itof_mag;
    logic [4:0]        lead;
    logic [`FPU_W-1:0] norm;
    logic [`FPU_W-1:0] itof_res;

    // float to integer, truncating toward zero.
    always_comb begin
        shamt    = issue.xc.exp - 8'(`FPU_BIAS);
        wide     = 55'({1'b1, issue.xc.mant}) << shamt[4:0];
        ftoi_mag = wide[53:23];

        if (issue.xc.is_nan) begin
            ftoi_res = 32'h7fffffff;
        end else if (issue.xc.is_zero || issue.xc.exp < 8'(`FPU_BIAS)) begin
            ftoi_res = 32'd0;
        end else if (issue.xc.exp >= 8'(`FPU_BIAS + 31)) begin
            // -2^31 itself lands here and is exact.
            ftoi_res = issue.xc.sign ? 32'h80000000 : 32'h7fffffff;
        end else if (issue.xc.sign) begin
            ftoi_res = -{1'b0, ftoi_mag};
        end else begin
            ftoi_res = {1'b0, ftoi_mag};
        end
    end

    // signed integer to float.
    always_comb begin
        itof_mag = issue.x[31] ? -issue.x : issue.x;
        lead = 5'd0;
        for (int i = 0; i < `FPU_W; i++) begin
            if (itof_mag[i]) begin
                lead = 5'(i);
            end
        end
        norm = itof_mag << (5'd31 - lead);

        if (issue.x == 32'd0) begin
            itof_res = 32'd0;
        end else begin
            // bits below the 24 kept ones are dropped.
            itof_res = {issue.x[31], 8'(`FPU_BIAS) + 8'(lead), norm[30:8]};
        end
    end

    assign res = (issue.op == fpu_pkg::OP_FTOI) ? ftoi_res : itof_res;

endmodule

`default_nettype wire

//--- hdl/fpu_sign_cmp.sv
`timescale 1ns/1ns
`default_nettype none
`include "fpu_defines.svh"

module fpu_sign_cmp (
    input  wire fpu_pkg::fpu_issue_t issue,
    output logic [`FPU_W-1:0]        res
);

    logic [30:0] x_mag;
    logic [30:0] y_mag;
    logic        any_nan;
    logic        both_zero;
    logic        eq;
    logic        lt;

    always_comb begin
        x_mag     = {issue.xc.exp, issue.xc.mant};
        y_mag     = {issue.yc.exp, issue.yc.mant};
        any_nan   = issue.xc.is_nan || issue.yc.is_nan;
        both_zero = issue.xc.is_zero && issue.yc.is_zero;

        // +0 and -0 compare equal.
        eq = !any_nan && (both_zero || (issue.xc.sign == issue.yc.sign && x_mag == y_mag));

        if (any_nan || both_zero) begin
            lt = 1'b0;
        end else if (issue.xc.sign != issue.yc.sign) begin
            lt = issue.xc.sign;
        end else if (issue.xc.sign) begin
            lt = x_mag > y_mag;
        end else begin
            lt = x_mag < y_mag;
        end

        case (issue.op)
            fpu_pkg::OP_SGNJ:  res = {issue.y[31], issue.x[30:0]};
            fpu_pkg::OP_SGNJN: res = {~issue.y[31], issue.x[30:0]};
            fpu_pkg::OP_SGNJX: res = {issue.x[31] ^ issue.y[31], issue.x[30:0]};
            fpu_pkg::OP_FEQ:   res = 32'(eq);
            fpu_pkg::OP_FLT:   res = 32'(lt);
            default:           res = 32'(lt | eq);
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/fpu_select.sv
`timescale 1ns/1ns
`default_nettype none
`include "fpu_defines.svh"

module fpu_select (
    input  wire                  clk,
    input  wire                  rstn,
    input  wire fpu_pkg::fpu_issue_t issue,
    input  wire [`FPU_W-1:0]     mul_res,
    input  wire [`FPU_W-1:0]     cvt_res,
    input  wire [`FPU_W-1:0]     sc_res,
    output fpu_pkg::fpu_result_t result
);

    logic [`FPU_W-1:0] word;

    always_comb begin
        case (issue.op)
            fpu_pkg::OP_MUL:                   word = mul_res;
            fpu_pkg::OP_FTOI, fpu_pkg::OP_ITOF: word = cvt_res;
            fpu_pkg::OP_UNSUP:                 word = `FPU_QNAN;
            default:                           word = sc_res;
        endcase
    end

    // data holds its last value between operations.
    always_ff @(posedge clk) begin
        if (!rstn) begin
            result <= '0;
        end else begin
            result.valid <= issue.valid;
            if (issue.valid) begin
                result.data <= word;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/fpu_short.sv
`timescale 1ns/1ns
`default_nettype none
`include "fpu_defines.svh"

module fpu_short (
    input  wire                clk,
    input  wire                rstn,
    input  wire                en,
    input  wire [`FPU_W-1:0]   x,
    input  wire [`FPU_W-1:0]   y,
    input  wire [4:0]          funct5,
    input  wire [2:0]          rm,
    output wire [`FPU_W-1:0]   res,
    output wire                valid
);

    fpu_pkg::fpu_issue_t  issue;
    fpu_pkg::fpu_result_t result;
    wire [`FPU_W-1:0]     mul_res;
    wire [`FPU_W-1:0]     cvt_res;
    wire [`FPU_W-1:0]     sc_res;

    fpu_decode u_decode (
        .clk    (clk),
        .rstn   (rstn),
        .en     (en),
        .x      (x),
        .y      (y),
        .funct5 (funct5),
        .rm     (rm),
        .issue  (issue)
    );

    fpu_mul u_mul (
        .issue (issue),
        .res   (mul_res)
    );

    fpu_convert u_convert (
        .issue (issue),
        .res   (cvt_res)
    );

    fpu_sign_cmp u_sign_cmp (
        .issue (issue),
        .res   (sc_res)
    );

    fpu_select u_select (
        .clk     (clk),
        .rstn    (rstn),
        .issue   (issue),
        .mul_res (mul_res),
        .cvt_res (cvt_res),
        .sc_res  (sc_res),
        .result  (result)
    );

    assign res   = result.data;
    assign valid = result.valid;

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

//--- tests/fpu_short_chk.sv
`timescale 1ns/1ns
`include "fpu_defines.svh"

module fpu_short_chk (
    input logic              clk,
    input logic              rstn,
    input logic              en,
    input logic              valid,
    input logic [`FPU_W-1:0] res
);

    int failures = 0;

    // every sampled en comes back as exactly one valid, FPU_LATENCY edges later.
    valid_follows_en: assert property (
        @(posedge clk) disable iff (!rstn) valid == $past(en, `FPU_LATENCY)
    ) else begin
        failures++;
        $error("valid is not en delayed by %0d cycles", `FPU_LATENCY);
    end

    res_known: assert property (
        @(posedge clk) disable iff (!rstn) valid |-> !$isunknown(res)
    ) else begin
        failures++;
        $error("res has unknown bits while valid is high");
    end

    // the reset is synchronous, so valid clears on the edge that sees rstn low.
    valid_low_in_reset: assert property (
        @(posedge clk) !rstn |=> !valid
    ) else begin
        failures++;
        $error("valid is high during reset");
    end

endmodule

bind fpu_short fpu_short_chk u_chk (
    .clk   (clk),
    .rstn  (rstn),
    .en    (en),
    .valid (valid),
    .res   (res)
);

//--- tests/fpu_short_tb.sv
`timescale 1ns/1ns
`include "fpu_defines.svh"

module fpu_short_tb;

    localparam int CLK_NS       = 100;
    localparam int RESET_CYCLES = 3;
    localparam int N_DIRECTED   = 33;
    localparam int N_MUL_RAND   = 200;
    localparam int N_SC_RAND    = 10;
    localparam int N_BURST      = 64;
    localparam int PLANNED_OPS  = N_DIRECTED + N_MUL_RAND + 6 * N_SC_RAND + N_BURST;
    localparam int WATCHDOG_NS  = (PLANNED_OPS + RESET_CYCLES + 20) * CLK_NS;
    localparam logic [4:0] BURST_F5 [6] = '{`FPU_F5_FMUL, `FPU_F5_FTOI, `FPU_F5_ITOF,
                                            `FPU_F5_FSGNJ, `FPU_F5_FCMP, `FPU_F5_FADD};

    logic              clk;
    logic              rstn;
    logic              en;
    logic [`FPU_W-1:0] x;
    logic [`FPU_W-1:0] y;
    logic [4:0]        funct5;
    logic [2:0]        rm;
    wire  [`FPU_W-1:0] res;
    wire               valid;

    logic [`FPU_W-1:0] expected [$];
    logic [`FPU_W-1:0] want;
    logic [`FPU_W-1:0] ra;
    logic [`FPU_W-1:0] rb;
    integer            seed;
    int                errors;
    int                cycles;
    int                pick;

    tb_clock #(.PERIOD_NS(CLK_NS)) u_clock (.clk(clk));

    fpu_short UUT (
        .clk    (clk),
        .rstn   (rstn),
        .en     (en),
        .x      (x),
        .y      (y),
        .funct5 (funct5),
        .rm     (rm),
        .res    (res),
        .valid  (valid)
    );

    // expected result of one operation, worked out from the FPU result rules.
    function automatic logic [`FPU_W-1:0] fpu_model(input logic [4:0] f5,
                                                    input logic [2:0] mode,
                                                    input logic [`FPU_W-1:0] a,
                                                    input logic [`FPU_W-1:0] b);
        logic        s;
        logic        nan_a, nan_b, inf_a, inf_b, zero_a, zero_b;
        logic        eq, lt;
        logic [47:0] p;
        logic [63:0] wide;
        logic [31:0] mag;
        logic [30:0] mag_a, mag_b;
        int          e;
        int          lead;
        nan_a  = (a[30:23] == 8'hff) && (a[22:0] != 0);
        nan_b  = (b[30:23] == 8'hff) && (b[22:0] != 0);
        inf_a  = (a[30:23] == 8'hff) && (a[22:0] == 0);
        inf_b  = (b[30:23] == 8'hff) && (b[22:0] == 0);
        zero_a = (a[30:23] == 0);
        zero_b = (b[30:23] == 0);
        case (f5)
            `FPU_F5_FMUL: begin
                s = a[31] ^ b[31];
                if (nan_a || nan_b || (zero_a && inf_b) || (inf_a && zero_b)) return `FPU_QNAN;
                if (inf_a || inf_b) return {s, 8'hff, 23'd0};
                if (zero_a || zero_b) return {s, 31'd0};
                p = {1'b1, a[22:0]} * {1'b1, b[22:0]};
                e = a[30:23] + b[30:23] - `FPU_BIAS;
                if (p[47]) begin
                    e = e + 1;
                    p = p >> 1;
                end
                if (e > 254) return {s, 31'h7f7fffff};
                if (e < 1) return {s, 31'd0};
                return {s, e[7:0], p[45:23]};
            end
            `FPU_F5_FTOI: begin
                if (nan_a) return 32'h7fffffff;
                if (zero_a || a[30:23] < `FPU_BIAS) return 32'd0;
                if (a[30:23] >= `FPU_BIAS + 31) return a[31] ? 32'h80000000 : 32'h7fffffff;
                wide = 64'({1'b1, a[22:0]}) << (a[30:23] - `FPU_BIAS);
                mag  = wide[54:23];
                return a[31] ? -mag : mag;
            end
            `FPU_F5_ITOF: begin
                if (a == 0) return 32'd0;
                mag  = a[31] ? -a : a;
                lead = 0;
                for (int i = 0; i < `FPU_W; i++) begin
                    if (mag[i]) lead = i;
                end
                mag = mag << (31 - lead);
                return {a[31], 8'(`FPU_BIAS + lead), mag[30:8]};
            end
            `FPU_F5_FSGNJ: begin
                case (mode)
                    3'b000:  s = b[31];
                    3'b001:  s = ~b[31];
                    default: s = a[31] ^ b[31];
                endcase
                return {s, a[30:0]};
            end
            `FPU_F5_FCMP: begin
                if (nan_a || nan_b) return 32'd0;
                // a subnormal compares as a zero of the same sign.
                mag_a = zero_a ? 31'd0 : a[30:0];
                mag_b = zero_b ? 31'd0 : b[30:0];
                eq = (mag_a == 0 && mag_b == 0) || (a[31] == b[31] && mag_a == mag_b);
                if (mag_a == 0 && mag_b == 0) begin
                    lt = 1'b0;
                end else if (a[31] != b[31]) begin
                    lt = a[31];
                end else begin
                    lt = a[31] ? (mag_a > mag_b) : (mag_a < mag_b);
                end
                case (mode)
                    3'b010:  return {31'd0, eq};
                    3'b001:  return {31'd0, lt};
                    default: return {31'd0, lt | eq};
                endcase
            end
            default: return `FPU_QNAN;
        endcase
    endfunction

    task automatic issue_op(input logic [4:0] f5, input logic [2:0] mode,
                            input logic [`FPU_W-1:0] a, input logic [`FPU_W-1:0] b);
        @(posedge clk);
        en     <= 1'b1;
        funct5 <= f5;
        rm     <= mode;
        x      <= a;
        y      <= b;
        expected.push_back(fpu_model(f5, mode, a, b));
    endtask

    task automatic idle();
        @(posedge clk);
        en <= 1'b0;
    endtask

    task automatic check_quiet(input string when);
        @(negedge clk);
        assert (valid === 1'b0) else begin
            errors++;
            $display("Error at %0t: valid is high %s", $time, when);
        end
    endtask

    // results are taken at the falling edge, half a cycle after they settle.
    always @(negedge clk) begin
        if (rstn && valid === 1'b1) begin
            assert (expected.size() != 0) else begin
                errors++;
                $display("Error at %0t: valid is high but no result was expected", $time);
            end
            if (expected.size() != 0) begin
                want = expected.pop_front();
                assert (res === want) else begin
                    errors++;
                    $display("Mismatch at %0t: res expected %h, got %h", $time, want, res);
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Error: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        seed   = 32'hfe2b;
        errors = 0;
        rstn   = 1'b0;
        en     = 1'b0;
        x      = '0;
        y      = '0;
        funct5 = '0;
        rm     = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;

        repeat (3) check_quiet("with no operation issued");
        issue_op(`FPU_F5_FMUL, 3'b001, 32'h3fc00000, 32'h40000000);
        idle();
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (valid !== 1'b1 && cycles < 10);
        assert (cycles == `FPU_LATENCY) else begin
            errors++;
            $display("Error: valid came %0d cycles after en instead of %0d", cycles, `FPU_LATENCY);
        end
        check_quiet("for more than one cycle after a single en");

        issue_op(`FPU_F5_FMUL, 3'b001, 32'h7fc00001, 32'h3f800000);
        issue_op(`FPU_F5_FMUL, 3'b001, 32'h00000000, 32'h7f800000);
        issue_op(`FPU_F5_FMUL, 3'b001, 32'h7f800000, 32'hc0000000);
        issue_op(`FPU_F5_FMUL, 3'b001, 32'h80000000, 32'h40400000);
        issue_op(`FPU_F5_FMUL, 3'b001, 32'h7f000000, 32'h40800000);
        issue_op(`FPU_F5_FMUL, 3'b001, 32'h00800000, 32'h00800000);
        issue_op(`FPU_F5_FMUL, 3'b001, 32'h80400000, 32'h3f800000);
        issue_op(`FPU_F5_FMUL, 3'b001, 32'h3fc00000, 32'hc0000000);
        repeat (N_MUL_RAND) begin
            ra = $random(seed);
            rb = $random(seed);
            issue_op(`FPU_F5_FMUL, 3'b001, ra, rb);
        end

        issue_op(`FPU_F5_FTOI, 3'b001, 32'h3fc00000, 32'h0);
        issue_op(`FPU_F5_FTOI, 3'b001, 32'hc0700000, 32'h0);
        issue_op(`FPU_F5_FTOI, 3'b001, 32'h7fc00000, 32'h0);
        issue_op(`FPU_F5_FTOI, 3'b001, 32'h4f000000, 32'h0);
        issue_op(`FPU_F5_FTOI, 3'b001, 32'hcf000000, 32'h0);
        issue_op(`FPU_F5_FTOI, 3'b001, 32'hcf800000, 32'h0);
        issue_op(`FPU_F5_FTOI, 3'b001, 32'h4effffff, 32'h0);
        issue_op(`FPU_F5_ITOF, 3'b001, 32'h00000005, 32'h0);
        issue_op(`FPU_F5_ITOF, 3'b001, 32'hfffffffd, 32'h0);
        issue_op(`FPU_F5_ITOF, 3'b001, 32'h80000000, 32'h0);
        issue_op(`FPU_F5_ITOF, 3'b001, 32'h7fffffff, 32'h0);
        issue_op(`FPU_F5_ITOF, 3'b001, 32'h01000001, 32'h0);

        // rm 0, 1 and 2 cover every sign-injection and compare variant.
        for (int k = 0; k < 3; k++) begin
            issue_op(`FPU_F5_FCMP, 3'(k), 32'h00000000, 32'h80000000);
            issue_op(`FPU_F5_FCMP, 3'(k), 32'h7fc00000, 32'h3f800000);
            issue_op(`FPU_F5_FCMP, 3'(k), 32'h40400000, 32'h40400000);
            repeat (N_SC_RAND) begin
                ra = $random(seed);
                rb = $random(seed);
                issue_op(`FPU_F5_FSGNJ, 3'(k), ra, rb);
                issue_op(`FPU_F5_FCMP, 3'(k), ra, rb);
            end
        end

        issue_op(`FPU_F5_FADD, 3'b001, 32'h3f800000, 32'h3f800000);
        issue_op(`FPU_F5_FSUB, 3'b001, 32'h3f800000, 32'h3f800000);
        issue_op(5'b01111, 3'b001, 32'h3f800000, 32'h3f800000);

        repeat (N_BURST) begin
            pick = {$random(seed)} % 6;
            ra   = $random(seed);
            rb   = $random(seed);
            issue_op(BURST_F5[pick], 3'($random(seed)), ra, rb);
        end

        idle();
        cycles = 0;
        while (expected.size() != 0 && cycles < 10) begin
            @(negedge clk);
            cycles++;
        end
        @(posedge clk);
        assert (expected.size() == 0) else begin
            errors++;
            $display("Error: %0d expected results never came out", expected.size());
        end
        // failures of the bound timing checker count as errors too.
        errors += UUT.u_chk.failures;
        $display("Run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- fpu_short.f
+incdir+hdl
hdl/fpu_pkg.sv
hdl/fpu_decode.sv
hdl/fpu_mul.sv
hdl/fpu_convert.sv
hdl/fpu_sign_cmp.sv
hdl/fpu_select.sv
hdl/fpu_short.sv
tests/tb_clock.sv
tests/fpu_short_chk.sv
tests/fpu_short_tb.sv

//--- Bender.yml
package:
  name: fpu_short

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fpu_pkg.sv
      - hdl/fpu_decode.sv
      - hdl/fpu_mul.sv
      - hdl/fpu_convert.sv
      - hdl/fpu_sign_cmp.sv
      - hdl/fpu_select.sv
      - hdl/fpu_short.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/tb_clock.sv
      - tests/fpu_short_chk.sv
      - tests/fpu_short_tb.sv
